/* common/csr_macros.svh */
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// ========================================
// widths
// ========================================
`define CSR_XLEN            32
`define CSR_ADDR_W          12

// ========================================
// id and isa constants
// ========================================
`define CSR_MARCHID         32'h0000_0023
// mxl = 1 (32 bit), base integer isa
`define CSR_ISA_CODE        32'h4000_0100

// ========================================
// interrupt bit positions in mie and mip
// ========================================
`define CSR_IRQ_MSI         3
`define CSR_IRQ_MTI         7
`define CSR_IRQ_MEI         11
`define CSR_IRQ_MVU         16

`define CSR_IRQ_MASK        ((32'h1 << `CSR_IRQ_MSI) | (32'h1 << `CSR_IRQ_MTI) | \
                             (32'h1 << `CSR_IRQ_MEI) | (32'h1 << `CSR_IRQ_MVU))

// exception codes
`define CSR_CAUSE_ILLEGAL   32'd2

`endif

/* common/csr_pkg.sv */
`default_nettype none

`include "csr_macros.svh"

package csr_pkg;

    // supported csr addresses
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_MSTATUS        = 12'h300,
        CSR_MISA           = 12'h301,
        CSR_MIE            = 12'h304,
        CSR_MTVEC          = 12'h305,
        CSR_MEPC           = 12'h341,
        CSR_MCAUSE         = 12'h342,
        CSR_MTVAL          = 12'h343,
        CSR_MIP            = 12'h344,
        // custom range for the mvu
        CSR_MVU_WBASEPTR   = 12'h7C0,
        CSR_MVU_IBASEPTR   = 12'h7C1,
        CSR_MVU_SBASEPTR   = 12'h7C2,
        CSR_MVU_BBASEPTR   = 12'h7C3,
        CSR_MVU_OBASEPTR   = 12'h7C4,
        CSR_MVU_PRECISION  = 12'h7C5,
        CSR_MVU_QUANT      = 12'h7C6,
        CSR_MVU_SCALER     = 12'h7C7,
        CSR_MVU_CONFIG1    = 12'h7C8,
        CSR_MVU_COMMAND    = 12'h7C9,
        CSR_MCYCLE         = 12'hB00,
        CSR_MCYCLEH        = 12'hB80,
        CSR_MVENDORID      = 12'hF11,
        CSR_MARCHID        = 12'hF12,
        CSR_MIMPID         = 12'hF13,
        CSR_MHARTID        = 12'hF14
    } csr_addr_e;

    typedef enum logic [2:0] {
        CSR_OP_NONE  = 3'd0,
        CSR_OP_RW    = 3'd1,
        CSR_OP_SET   = 3'd2,
        CSR_OP_CLEAR = 3'd3,
        CSR_OP_MRET  = 3'd4
    } csr_op_e;

    // standard rv32 mstatus layout, msb first
    typedef struct packed {
        logic       sd;
        logic [7:0] wpri3;
        logic       tsr;
        logic       tw;
        logic       tvm;
        logic       mxr;
        logic       sum;
        logic       mprv;
        logic [1:0] xs;
        logic [1:0] fs;
        logic [1:0] mpp;
        logic [1:0] wpri2;
        logic       spp;
        logic       mpie;
        logic       wpri1;
        logic       spie;
        logic       upie;
        logic       mie;
        logic       wpri0;
        logic       sie;
        logic       uie;
    } mstatus_t;

    typedef union packed {
        logic [`CSR_XLEN-1:0] raw;
        mstatus_t             mstatus;
    } csr_word_u;

    // addr stays plain so unmapped addresses can be requested
    typedef struct packed {
        csr_op_e                op;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_XLEN-1:0]   wdata;
    } csr_req_t;

    typedef struct packed {
        logic                 we;
        csr_addr_e            addr;
        logic [`CSR_XLEN-1:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0] rdata;
        logic                 hit;
    } csr_rd_t;

    typedef struct packed {
        logic                 valid;
        logic [`CSR_XLEN-1:0] cause;
    } csr_exc_t;

    typedef struct packed {
        logic                 valid;
        logic [`CSR_XLEN-1:0] target;
    } irq_evt_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0] wbaseptr;
        logic [`CSR_XLEN-1:0] ibaseptr;
        logic [`CSR_XLEN-1:0] sbaseptr;
        logic [`CSR_XLEN-1:0] bbaseptr;
        logic [`CSR_XLEN-1:0] obaseptr;
        logic [`CSR_XLEN-1:0] precision;
        logic [`CSR_XLEN-1:0] quant;
        logic [`CSR_XLEN-1:0] scaler;
        logic [`CSR_XLEN-1:0] config1;
    } mvu_cfg_t;

endpackage

`default_nettype wire

/* design/csr_access_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csr_access_ctrl import csr_pkg::*; (
    input  wire csr_req_t        req_i,
    input  wire csr_rd_t         m_rd_i,
    input  wire csr_rd_t         mvu_rd_i,
    output csr_wr_t              wr_o,
    output logic                 mret_o,
    output logic [`CSR_XLEN-1:0] rdata_o,
    output csr_exc_t             exc_o
);

    logic                 any_hit;
    logic                 is_access;
    logic [`CSR_XLEN-1:0] old_val;
    logic [`CSR_XLEN-1:0] new_val;

    // ========================================
    // read merge
    // ========================================
    // only one bank can own an address
    assign any_hit = m_rd_i.hit | mvu_rd_i.hit;
    assign old_val = m_rd_i.hit ? m_rd_i.rdata : mvu_rd_i.rdata;

    // ========================================
    // op decode and write data
    // ========================================
    always_comb begin
        is_access = 1'b0;
        mret_o    = 1'b0;
        new_val   = req_i.wdata;

        case (req_i.op)
            CSR_OP_RW: begin
                is_access = 1'b1;
            end
            CSR_OP_SET: begin
                is_access = 1'b1;
                new_val   = old_val | req_i.wdata;
            end
            CSR_OP_CLEAR: begin
                is_access = 1'b1;
                new_val   = old_val & ~req_i.wdata;
            end
            // return has no read or write side effect
            CSR_OP_MRET: begin
                mret_o = 1'b1;
            end
            default: begin
                is_access = 1'b0;
            end
        endcase
    end

    // a miss never reaches the banks
    assign wr_o.we   = is_access & any_hit;
    assign wr_o.addr = csr_addr_e'(req_i.addr);
    assign wr_o.data = new_val;

    assign rdata_o = (is_access && any_hit) ? old_val : '0;

    // ========================================
    // illegal access
    // ========================================
    assign exc_o.valid = is_access & ~any_hit;
    assign exc_o.cause = (is_access && !any_hit) ? `CSR_CAUSE_ILLEGAL : '0;

endmodule

`default_nettype wire

/* machine/m_mode_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module m_mode_regs import csr_pkg::*; #(
    parameter int HART_ID = 0
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire csr_wr_t              wr_i,
    input  wire csr_addr_e            rd_addr_i,
    input  wire logic                 mret_i,
    input  wire logic [`CSR_XLEN-1:0] boot_addr_i,
    input  wire logic [`CSR_XLEN-1:0] pc_i,
    input  wire logic [`CSR_XLEN-1:0] cause_i,
    input  wire logic                 cycle_en_i,
    input  wire logic                 irq_i,
    input  wire logic                 time_irq_i,
    input  wire logic                 ipi_i,
    input  wire logic                 mvu_irq_i,
    output csr_rd_t                   rd_o,
    output irq_evt_t                  irq_evt_o
);

    csr_word_u            wdata_u;
    mstatus_t             mstatus_q, mstatus_d;
    logic [`CSR_XLEN-1:0] mie_q, mie_d;
    logic [`CSR_XLEN-1:0] mip_q, mip_d;
    logic [`CSR_XLEN-1:0] mtvec_q, mtvec_d;
    logic [`CSR_XLEN-1:0] mepc_q, mepc_d;
    logic [`CSR_XLEN-1:0] mcause_q, mcause_d;
    logic [`CSR_XLEN-1:0] mtval_q, mtval_d;
    logic [63:0]          mcycle_q, mcycle_d;
    logic                 boot_load_q;
    logic                 mip_wr;
    logic                 irq_take;

    // the same write word seen as a plain value and as mstatus fields
    assign wdata_u.raw = wr_i.data;
    assign mip_wr      = wr_i.we && (wr_i.addr == CSR_MIP);

    assign irq_take = mstatus_q.mie & mip_q[`CSR_IRQ_MVU] & mie_q[`CSR_IRQ_MVU];

    // ========================================
    // read mux
    // ========================================
    always_comb begin
        rd_o.hit   = 1'b1;
        rd_o.rdata = '0;
        case (rd_addr_i)
            CSR_MVENDORID: rd_o.rdata = '0;
            CSR_MARCHID:   rd_o.rdata = `CSR_MARCHID;
            CSR_MIMPID:    rd_o.rdata = '0;
            CSR_MHARTID:   rd_o.rdata = HART_ID;
            CSR_MISA:      rd_o.rdata = `CSR_ISA_CODE;
            CSR_MSTATUS:   rd_o.rdata = mstatus_q;
            CSR_MIE:       rd_o.rdata = mie_q;
            CSR_MIP:       rd_o.rdata = mip_q;
            CSR_MTVEC:     rd_o.rdata = mtvec_q;
            CSR_MEPC:      rd_o.rdata = mepc_q;
            CSR_MCAUSE:    rd_o.rdata = mcause_q;
            CSR_MTVAL:     rd_o.rdata = mtval_q;
            CSR_MCYCLE:    rd_o.rdata = mcycle_q[31:0];
            CSR_MCYCLEH:   rd_o.rdata = mcycle_q[63:32];
            default:       rd_o.hit   = 1'b0;
        endcase
    end

    // ========================================
    // next state
    // ========================================
    always_comb begin
        mstatus_d = mstatus_q;
        mie_d     = mie_q;
        mtvec_d   = boot_load_q ? boot_addr_i : mtvec_q;
        mepc_d    = mepc_q;
        mcause_d  = mcause_q;
        mtval_d   = mtval_q;
        mcycle_d  = cycle_en_i ? mcycle_q + 64'd1 : mcycle_q;

        // id registers, misa and the counter ignore writes
        if (wr_i.we) begin
            case (wr_i.addr)
                CSR_MSTATUS: begin
                    mstatus_d      = wdata_u.mstatus;
                    mstatus_d.sd   = 1'b0;
                    mstatus_d.xs   = 2'b00;
                    mstatus_d.fs   = 2'b00;
                    mstatus_d.upie = 1'b0;
                    mstatus_d.uie  = 1'b0;
                end
                CSR_MIE:    mie_d    = wdata_u.raw & `CSR_IRQ_MASK;
                CSR_MTVEC:  mtvec_d  = wdata_u.raw;
                CSR_MEPC:   mepc_d   = {wdata_u.raw[31:1], 1'b0};
                CSR_MCAUSE: mcause_d = wdata_u.raw;
                CSR_MTVAL:  mtval_d  = wdata_u.raw;
                default: begin
                    mcause_d = mcause_q;
                end
            endcase
        end

        // pending bits, mvu one is sticky until software clears it
        mip_d                = '0;
        mip_d[`CSR_IRQ_MSI]  = ipi_i;
        mip_d[`CSR_IRQ_MTI]  = time_irq_i;
        mip_d[`CSR_IRQ_MEI]  = irq_i;
        mip_d[`CSR_IRQ_MVU]  = mvu_irq_i |
                               (mip_wr ? wdata_u.raw[`CSR_IRQ_MVU] : mip_q[`CSR_IRQ_MVU]);

        // trap entry wins over a return in the same cycle
        if (irq_take) begin
            mepc_d         = pc_i;
            mcause_d       = {1'b1, 26'b0, cause_i[4:0]};
            mstatus_d.mpie = mstatus_q.mie;
            mstatus_d.mie  = 1'b0;
        end else if (mret_i) begin
            mstatus_d.mie  = mstatus_q.mpie;
            mstatus_d.mpie = 1'b1;
        end
    end

    // event to fetch
    assign irq_evt_o.valid  = irq_take | mret_i;
    assign irq_evt_o.target = irq_take ? mtvec_q : mepc_q;

    // ========================================
    // state
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q   <= '0;
            mie_q       <= '0;
            mip_q       <= '0;
            mtvec_q     <= '0;
            mepc_q      <= '0;
            mcause_q    <= '0;
            mtval_q     <= '0;
            mcycle_q    <= '0;
            boot_load_q <= 1'b1;
        end else begin
            mstatus_q   <= mstatus_d;
            mie_q       <= mie_d;
            mip_q       <= mip_d;
            mtvec_q     <= mtvec_d;
            mepc_q      <= mepc_d;
            mcause_q    <= mcause_d;
            mtval_q     <= mtval_d;
            mcycle_q    <= mcycle_d;
            boot_load_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* mvu/mvu_csr_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module mvu_csr_bank import csr_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire csr_wr_t   wr_i,
    input  wire csr_addr_e rd_addr_i,
    output csr_rd_t        rd_o,
    output mvu_cfg_t       mvu_cfg_o,
    output logic           mvu_start_o
);

    mvu_cfg_t             cfg_q;
    logic [`CSR_XLEN-1:0] command_q;
    logic                 start_q;

    // ========================================
    // read mux
    // ========================================
    always_comb begin
        rd_o.hit   = 1'b1;
        rd_o.rdata = '0;
        case (rd_addr_i)
            CSR_MVU_WBASEPTR:  rd_o.rdata = cfg_q.wbaseptr;
            CSR_MVU_IBASEPTR:  rd_o.rdata = cfg_q.ibaseptr;
            CSR_MVU_SBASEPTR:  rd_o.rdata = cfg_q.sbaseptr;
            CSR_MVU_BBASEPTR:  rd_o.rdata = cfg_q.bbaseptr;
            CSR_MVU_OBASEPTR:  rd_o.rdata = cfg_q.obaseptr;
            CSR_MVU_PRECISION: rd_o.rdata = cfg_q.precision;
            CSR_MVU_QUANT:     rd_o.rdata = cfg_q.quant;
            CSR_MVU_SCALER:    rd_o.rdata = cfg_q.scaler;
            CSR_MVU_CONFIG1:   rd_o.rdata = cfg_q.config1;
            CSR_MVU_COMMAND:   rd_o.rdata = command_q;
            default:           rd_o.hit   = 1'b0;
        endcase
    end

    // ========================================
    // register writes
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q     <= '0;
            command_q <= '0;
            start_q   <= 1'b0;
        end else begin
            // start is a one cycle pulse after a real command write
            start_q <= 1'b0;
            if (wr_i.we) begin
                case (wr_i.addr)
                    CSR_MVU_WBASEPTR:  cfg_q.wbaseptr  <= wr_i.data;
                    CSR_MVU_IBASEPTR:  cfg_q.ibaseptr  <= wr_i.data;
                    CSR_MVU_SBASEPTR:  cfg_q.sbaseptr  <= wr_i.data;
                    CSR_MVU_BBASEPTR:  cfg_q.bbaseptr  <= wr_i.data;
                    CSR_MVU_OBASEPTR:  cfg_q.obaseptr  <= wr_i.data;
                    CSR_MVU_PRECISION: cfg_q.precision <= wr_i.data;
                    CSR_MVU_QUANT:     cfg_q.quant     <= wr_i.data;
                    CSR_MVU_SCALER:    cfg_q.scaler    <= wr_i.data;
                    CSR_MVU_CONFIG1:   cfg_q.config1   <= wr_i.data;
                    CSR_MVU_COMMAND: begin
                        command_q <= wr_i.data;
                        start_q   <= 1'b1;
                    end
                    default: begin
                        start_q <= 1'b0;
                    end
                endcase
            end
        end
    end

    // to the mvu
    assign mvu_cfg_o   = cfg_q;
    assign mvu_start_o = start_q;

endmodule

`default_nettype wire

/* design/csr_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csr_top import csr_pkg::*; #(
    parameter int HART_ID = 0
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire csr_req_t             req_i,
    input  wire logic [`CSR_XLEN-1:0] boot_addr_i,
    input  wire logic [`CSR_XLEN-1:0] pc_i,
    input  wire logic [`CSR_XLEN-1:0] cause_i,
    input  wire logic                 cycle_en_i,
    input  wire logic                 irq_i,
    input  wire logic                 time_irq_i,
    input  wire logic                 ipi_i,
    input  wire logic                 mvu_irq_i,
    output logic [`CSR_XLEN-1:0]      rdata_o,
    output csr_exc_t                  exc_o,
    output irq_evt_t                  irq_evt_o,
    output mvu_cfg_t                  mvu_cfg_o,
    output logic                      mvu_start_o
);

    csr_addr_e req_addr;
    csr_wr_t   wr;
    csr_rd_t   m_rd;
    csr_rd_t   mvu_rd;
    logic      mret;

    // both banks decode the raw request address on their own
    assign req_addr = csr_addr_e'(req_i.addr);

    csr_access_ctrl u_access_ctrl (
        .req_i    (req_i),
        .m_rd_i   (m_rd),
        .mvu_rd_i (mvu_rd),
        .wr_o     (wr),
        .mret_o   (mret),
        .rdata_o  (rdata_o),
        .exc_o    (exc_o)
    );

    m_mode_regs #(
        .HART_ID (HART_ID)
    ) u_m_mode_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_i        (wr),
        .rd_addr_i   (req_addr),
        .mret_i      (mret),
        .boot_addr_i (boot_addr_i),
        .pc_i        (pc_i),
        .cause_i     (cause_i),
        .cycle_en_i  (cycle_en_i),
        .irq_i       (irq_i),
        .time_irq_i  (time_irq_i),
        .ipi_i       (ipi_i),
        .mvu_irq_i   (mvu_irq_i),
        .rd_o        (m_rd),
        .irq_evt_o   (irq_evt_o)
    );

    mvu_csr_bank u_mvu_csr_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_i        (wr),
        .rd_addr_i   (req_addr),
        .rd_o        (mvu_rd),
        .mvu_cfg_o   (mvu_cfg_o),
        .mvu_start_o (mvu_start_o)
    );

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // reset released on a rising edge after the hold time
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* sim/csr_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csr_tb import csr_pkg::*;;

    localparam int          HART_ID         = 3;
    localparam int          CLK_PERIOD      = 4;
    localparam int          WATCHDOG_MARGIN = 100;
    localparam int          CFG_WORDS       = 9;
    localparam logic [31:0] BOOT_ADDR       = 32'h0000_8000;
    localparam logic [31:0] TRAP_CAUSE      = 32'h0000_0010;
    // sd, xs, fs, upie and uie
    localparam logic [31:0] MSTATUS_ZERO    = 32'h8001_E011;

    typedef struct packed {
        logic [2:0]  test;
        csr_op_e     op;
        logic [11:0] addr;
        logic [31:0] wdata;
        logic        mvu_irq;
        logic        cycle_en;
        logic [31:0] pc;
        logic [31:0] exp_rdata;
        logic        exp_exc;
        logic        exp_evt;
        logic [31:0] exp_target;
        logic        exp_start;
        mvu_cfg_t    exp_cfg;
    } step_t;

    logic        clk;
    logic        rst_n;
    csr_req_t    req_i;
    logic [31:0] boot_addr_i;
    logic [31:0] pc_i;
    logic [31:0] cause_i;
    logic        cycle_en_i;
    logic        irq_i;
    logic        time_irq_i;
    logic        ipi_i;
    logic        mvu_irq_i;
    logic [31:0] rdata_o;
    csr_exc_t    exc_o;
    irq_evt_t    irq_evt_o;
    mvu_cfg_t    mvu_cfg_o;
    logic        mvu_start_o;

    step_t       table_q[$];
    logic        table_ready;
    int          errors;
    int          checks;
    int          test_errors;
    int          test_checks;

    // reference model state, as seen in the window of the next step
    logic [31:0] ref_regs [0:4095];
    logic [63:0] ref_cycles;
    logic        ref_mip_mvu;
    logic        ref_start;
    logic [15:0] lfsr_q;

    tb_clk_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (4)
    ) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    csr_top #(
        .HART_ID (HART_ID)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req_i),
        .boot_addr_i (boot_addr_i),
        .pc_i        (pc_i),
        .cause_i     (cause_i),
        .cycle_en_i  (cycle_en_i),
        .irq_i       (irq_i),
        .time_irq_i  (time_irq_i),
        .ipi_i       (ipi_i),
        .mvu_irq_i   (mvu_irq_i),
        .rdata_o     (rdata_o),
        .exc_o       (exc_o),
        .irq_evt_o   (irq_evt_o),
        .mvu_cfg_o   (mvu_cfg_o),
        .mvu_start_o (mvu_start_o)
    );

    // ========================================
    // random words and the reference model
    // ========================================
    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_word(output logic [31:0] w);
        int b;
        w = '0;
        for (b = 0; b < 32; b++) begin
            lfsr_q = lfsr_step(lfsr_q);
            w      = {w[30:0], lfsr_q[0]};
        end
    endtask

    function automatic logic is_mvu_addr(input logic [11:0] a);
        return (a >= CSR_MVU_WBASEPTR) && (a <= CSR_MVU_COMMAND);
    endfunction

    function automatic logic is_mapped(input logic [11:0] a);
        case (a)
            CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE,
            CSR_MTVAL, CSR_MIP, CSR_MCYCLE, CSR_MCYCLEH, CSR_MVENDORID,
            CSR_MARCHID, CSR_MIMPID, CSR_MHARTID: return 1'b1;
            default: return is_mvu_addr(a);
        endcase
    endfunction

    function automatic logic [31:0] ref_read(input logic [11:0] a);
        case (a)
            CSR_MCYCLE:  return ref_cycles[31:0];
            CSR_MCYCLEH: return ref_cycles[63:32];
            CSR_MIP:     return ref_mip_mvu ? (32'h1 << `CSR_IRQ_MVU) : 32'h0;
            default:     return ref_regs[a];
        endcase
    endfunction

    // value a register holds after a write, ids and counters keep the old one
    function automatic logic [31:0] legal_value(input logic [11:0] a,
                                                input logic [31:0] old_v,
                                                input logic [31:0] data);
        case (a)
            CSR_MSTATUS: return data & ~MSTATUS_ZERO;
            CSR_MIE:     return data & `CSR_IRQ_MASK;
            CSR_MEPC:    return {data[31:1], 1'b0};
            CSR_MTVEC, CSR_MCAUSE, CSR_MTVAL: return data;
            default:     return is_mvu_addr(a) ? data : old_v;
        endcase
    endfunction

    task automatic add_step(input int test, input csr_op_e op, input logic [11:0] addr,
                            input logic [31:0] data, input logic irq);
        step_t       s;
        logic        access;
        logic        hit;
        logic        take;
        logic [31:0] old_v;
        logic [31:0] new_v;
        int          k;
        access = (op == CSR_OP_RW) || (op == CSR_OP_SET) || (op == CSR_OP_CLEAR);
        hit    = is_mapped(addr);
        old_v  = ref_read(addr);
        case (op)
            CSR_OP_SET:   new_v = old_v | data;
            CSR_OP_CLEAR: new_v = old_v & ~data;
            default:      new_v = data;
        endcase
        take = ref_regs[CSR_MSTATUS][3] & ref_mip_mvu & ref_regs[CSR_MIE][`CSR_IRQ_MVU];

        s.test       = test[2:0];
        s.op         = op;
        s.addr       = addr;
        s.wdata      = data;
        s.mvu_irq    = irq;
        s.cycle_en   = (table_q.size() % 3) != 2;
        s.pc         = 32'h0000_0100 + table_q.size() * 4;
        s.exp_rdata  = (access && hit) ? old_v : 32'h0;
        s.exp_exc    = access && !hit;
        s.exp_evt    = take || (op == CSR_OP_MRET);
        s.exp_target = take ? ref_regs[CSR_MTVEC] : ref_regs[CSR_MEPC];
        s.exp_start  = ref_start;
        // configuration words in address order, wbaseptr in the top word
        for (k = 0; k < CFG_WORDS; k++)
            s.exp_cfg[32 * CFG_WORDS - 1 - 32 * k -: 32] = ref_regs[CSR_MVU_WBASEPTR + k];
        table_q.push_back(s);

        // state after the clock edge that ends this step
        ref_start = access && hit && (addr == CSR_MVU_COMMAND);
        if (access && hit) begin
            if (addr == CSR_MIP)
                ref_mip_mvu = new_v[`CSR_IRQ_MVU];
            else
                ref_regs[addr] = legal_value(addr, old_v, new_v);
        end
        ref_mip_mvu = ref_mip_mvu | irq;
        if (take) begin
            ref_regs[CSR_MEPC]       = s.pc;
            ref_regs[CSR_MCAUSE]     = {1'b1, 26'b0, TRAP_CAUSE[4:0]};
            // mie was set, otherwise no trap
            ref_regs[CSR_MSTATUS][7] = 1'b1;
            ref_regs[CSR_MSTATUS][3] = 1'b0;
        end else if (op == CSR_OP_MRET) begin
            ref_regs[CSR_MSTATUS][3] = ref_regs[CSR_MSTATUS][7];
            ref_regs[CSR_MSTATUS][7] = 1'b1;
        end
        if (s.cycle_en)
            ref_cycles = ref_cycles + 64'd1;
    endtask

    // ========================================
    // stimulus table
    // ========================================
    task automatic build_table();
        logic [31:0] w;
        int          a;
        // reset values and the cycle counter
        add_step(0, CSR_OP_SET, CSR_MTVEC, 32'h0, 1'b0);
        add_step(0, CSR_OP_SET, CSR_MCYCLE, 32'h0, 1'b0);
        add_step(0, CSR_OP_NONE, 12'h000, 32'h0, 1'b0);
        add_step(0, CSR_OP_NONE, 12'h000, 32'h0, 1'b0);
        add_step(0, CSR_OP_SET, CSR_MCYCLE, 32'h0, 1'b0);
        add_step(0, CSR_OP_CLEAR, CSR_MCYCLEH, 32'h0, 1'b0);
        // plain registers and id constants
        random_word(w);
        add_step(1, CSR_OP_RW, CSR_MTVAL, w, 1'b0);
        add_step(1, CSR_OP_SET, CSR_MTVAL, 32'h0, 1'b0);
        random_word(w);
        add_step(1, CSR_OP_RW, CSR_MEPC, w | 32'h1, 1'b0);
        add_step(1, CSR_OP_SET, CSR_MEPC, 32'h0, 1'b0);
        for (a = 12'h7C0; a <= 12'h7C9; a++) begin
            random_word(w);
            add_step(1, CSR_OP_RW, a[11:0], w, 1'b0);
            add_step(1, CSR_OP_SET, a[11:0], 32'h0, 1'b0);
        end
        for (a = 12'hF11; a <= 12'hF14; a++)
            add_step(1, CSR_OP_SET, a[11:0], 32'h0, 1'b0);
        random_word(w);
        add_step(1, CSR_OP_RW, CSR_MISA, w, 1'b0);
        add_step(1, CSR_OP_SET, CSR_MISA, 32'h0, 1'b0);
        random_word(w);
        add_step(1, CSR_OP_RW, CSR_MHARTID, w, 1'b0);
        add_step(1, CSR_OP_SET, CSR_MHARTID, 32'h0, 1'b0);
        // set and clear on masked registers
        add_step(2, CSR_OP_RW, CSR_MIE, 32'h0, 1'b0);
        add_step(2, CSR_OP_SET, CSR_MIE, 32'hFFFF_FFFF, 1'b0);
        random_word(w);
        add_step(2, CSR_OP_CLEAR, CSR_MIE, w, 1'b0);
        add_step(2, CSR_OP_SET, CSR_MIE, 32'h0, 1'b0);
        random_word(w);
        add_step(2, CSR_OP_RW, CSR_MSTATUS, w, 1'b0);
        add_step(2, CSR_OP_SET, CSR_MSTATUS, 32'hFFFF_FFFF, 1'b0);
        random_word(w);
        add_step(2, CSR_OP_CLEAR, CSR_MSTATUS, w, 1'b0);
        add_step(2, CSR_OP_SET, CSR_MSTATUS, 32'h0, 1'b0);
        // unmapped addresses
        random_word(w);
        add_step(3, CSR_OP_RW, 12'h123, w, 1'b0);
        add_step(3, CSR_OP_SET, 12'h7CA, w, 1'b0);
        add_step(3, CSR_OP_CLEAR, 12'h7CA, w, 1'b0);
        add_step(3, CSR_OP_SET, CSR_MTVAL, 32'h0, 1'b0);
        add_step(3, CSR_OP_SET, CSR_MVU_CONFIG1, 32'h0, 1'b0);
        // mvu interrupt entry and return
        add_step(4, CSR_OP_RW, CSR_MTVEC, 32'h0000_1000, 1'b0);
        add_step(4, CSR_OP_RW, CSR_MIE, 32'h1 << `CSR_IRQ_MVU, 1'b0);
        add_step(4, CSR_OP_RW, CSR_MSTATUS, 32'h0000_0008, 1'b0);
        add_step(4, CSR_OP_NONE, 12'h000, 32'h0, 1'b1);
        add_step(4, CSR_OP_NONE, 12'h000, 32'h0, 1'b0);
        add_step(4, CSR_OP_SET, CSR_MEPC, 32'h0, 1'b0);
        add_step(4, CSR_OP_SET, CSR_MCAUSE, 32'h0, 1'b0);
        add_step(4, CSR_OP_SET, CSR_MSTATUS, 32'h0, 1'b0);
        add_step(4, CSR_OP_SET, CSR_MIP, 32'h0, 1'b0);
        add_step(4, CSR_OP_RW, CSR_MIP, 32'h0, 1'b0);
        add_step(4, CSR_OP_SET, CSR_MIP, 32'h0, 1'b0);
        add_step(4, CSR_OP_MRET, 12'h000, 32'h0, 1'b0);
        add_step(4, CSR_OP_SET, CSR_MSTATUS, 32'h0, 1'b0);
        // start strobe, an idle request on command must not raise it
        random_word(w);
        add_step(5, CSR_OP_RW, CSR_MVU_COMMAND, w, 1'b0);
        add_step(5, CSR_OP_NONE, 12'h000, 32'h0, 1'b0);
        add_step(5, CSR_OP_NONE, 12'h000, 32'h0, 1'b0);
        add_step(5, CSR_OP_NONE, CSR_MVU_COMMAND, w, 1'b0);
        add_step(5, CSR_OP_NONE, 12'h000, 32'h0, 1'b0);
    endtask

    function automatic string test_name(input int t);
        case (t)
            0:       return "reset_values";
            1:       return "rw_and_id";
            2:       return "set_clear";
            3:       return "illegal_access";
            4:       return "mvu_interrupt";
            default: return "mvu_start";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input int step);
        checks++;
        test_checks++;
        assert (got === exp) else begin
            $display("FAILED %s step %0d: got %h expected %h", name, step, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // ========================================
    // run
    // ========================================
    initial begin
        step_t s;
        int    i;
        int    k;
        req_i       = '0;
        boot_addr_i = BOOT_ADDR;
        pc_i        = '0;
        cause_i     = TRAP_CAUSE;
        cycle_en_i  = 1'b0;
        irq_i       = 1'b0;
        time_irq_i  = 1'b0;
        ipi_i       = 1'b0;
        mvu_irq_i   = 1'b0;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        test_checks = 0;
        table_ready = 1'b0;

        lfsr_q      = 16'd46440;
        ref_cycles  = '0;
        ref_mip_mvu = 1'b0;
        ref_start   = 1'b0;
        for (i = 0; i < 4096; i++)
            ref_regs[i] = '0;
        ref_regs[CSR_MARCHID] = `CSR_MARCHID;
        ref_regs[CSR_MHARTID] = HART_ID;
        ref_regs[CSR_MISA]    = `CSR_ISA_CODE;
        // loaded in the first cycle after reset
        ref_regs[CSR_MTVEC]   = BOOT_ADDR;
        build_table();
        table_ready = 1'b1;

        wait (rst_n === 1'b1);
        for (i = 0; i < table_q.size(); i++) begin
            s = table_q[i];
            @(posedge clk);
            req_i.op    <= s.op;
            req_i.addr  <= s.addr;
            req_i.wdata <= s.wdata;
            mvu_irq_i   <= s.mvu_irq;
            cycle_en_i  <= s.cycle_en;
            pc_i        <= s.pc;
            @(negedge clk);
            check_value("rdata_o", rdata_o, s.exp_rdata, i);
            check_value("exc_o.valid", 32'(exc_o.valid), 32'(s.exp_exc), i);
            if (s.exp_exc)
                check_value("exc_o.cause", exc_o.cause, `CSR_CAUSE_ILLEGAL, i);
            check_value("irq_evt_o.valid", 32'(irq_evt_o.valid), 32'(s.exp_evt), i);
            if (s.exp_evt)
                check_value("irq_evt_o.target", irq_evt_o.target, s.exp_target, i);
            check_value("mvu_start_o", 32'(mvu_start_o), 32'(s.exp_start), i);
            for (k = 0; k < CFG_WORDS; k++)
                check_value("mvu_cfg_o", mvu_cfg_o[32 * CFG_WORDS - 1 - 32 * k -: 32],
                            s.exp_cfg[32 * CFG_WORDS - 1 - 32 * k -: 32], i);
            if (i == table_q.size() - 1 || table_q[i + 1].test != s.test) begin
                $display("test %0d %s: %0d checks, %0d errors", s.test,
                         test_name(s.test), test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
        end

        $display("%0d steps, %0d checks, %0d errors", table_q.size(), checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (table_ready);
        #(table_q.size() * CLK_PERIOD + WATCHDOG_MARGIN);
        $display("watchdog expired before all steps were applied");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+common
common/csr_pkg.sv
design/csr_access_ctrl.sv
machine/m_mode_regs.sv
mvu/mvu_csr_bank.sv
design/csr_top.sv
sim/tb_clk_gen.sv
sim/csr_tb.sv

/* Bender.yml */
package:
  name: csr_file

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/csr_pkg.sv
      - design/csr_access_ctrl.sv
      - machine/m_mode_regs.sv
      - mvu/mvu_csr_bank.sv
      - design/csr_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_clk_gen.sv
      - sim/csr_tb.sv
